// File: common/rom_pkg.sv
// ROM subsystem definitions
package rom_pkg;

    // SDRAM byte offsets of each ROM region
    localparam logic [21:0] SND_START  = 22'h01_0000;
    localparam logic [21:0] SCR_START  = 22'h01_4000;
    localparam logic [21:0] OBJ_START  = 22'h01_C000;

    // Loader byte offset where the colour PROMs begin
    localparam logic [24:0] PROM_START = 25'h02_C000;

    // Slot address widths as seen by the CPUs and the tile engine
    localparam int MAIN_AW  = 16;
    localparam int SND_AW   = 14;
    localparam int SCR_AW   = 13;

    // SDRAM word address width
    localparam int SDRAM_AW = 22;

    // Slot indices, scroll has the highest priority
    localparam logic [1:0] SLOT_MAIN = 2'd0;
    localparam logic [1:0] SLOT_SND  = 2'd1;
    localparam logic [1:0] SLOT_SCR  = 2'd2;

    // Arbiter FSM encodings
    localparam logic [1:0] ARB_IDLE  = 2'd0;
    localparam logic [1:0] ARB_REQ   = 2'd1;
    localparam logic [1:0] ARB_RECV  = 2'd2;

    // Byte view of one SDRAM read word
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;     // even byte address
    } byte_pair_t;

    // One SDRAM read word, either half of a 32-bit fetch or two bytes
    typedef union packed {
        logic [15:0] whole;
        byte_pair_t  bytes;
    } sdram_word_u;

endpackage

// File: common/rom_slot_if.sv
// ROM slot bus
interface rom_slot_if;

    // Client side
    logic [15:0]           addr;
    logic                  cs;
    logic                  ok;
    logic [31:0]           data;

    // Arbiter side
    logic                  req;
    logic                  grant;
    logic [21:0]           fetch_addr;
    rom_pkg::sdram_word_u  word;
    logic                  dst;
    logic                  rdy;
    logic                  wide;

    modport client (
        output addr, cs,
        input  ok, data
    );

    modport slot (
        input  addr, cs, grant, word, dst, rdy,
        output ok, data, req, fetch_addr, wide
    );

    modport arb (
        input  req, fetch_addr, wide,
        output grant, word, dst, rdy
    );

endinterface

// File: rtl/dwnld_remap.sv
// Loader region remap
module dwnld_remap (
    input  logic [24:0] ioctl_addr,
    input  logic [ 7:0] ioctl_dout,
    output logic [24:0] dwn_addr,
    output logic [ 7:0] dwn_data,
    output logic        is_prom
);

    logic scr_rgn;
    logic obj_rgn;

    // Region decode on the raw loader address
    assign is_prom = ioctl_addr >= rom_pkg::PROM_START;
    assign scr_rgn = ioctl_addr >= {3'd0, rom_pkg::SCR_START} &&
                     ioctl_addr <  {3'd0, rom_pkg::OBJ_START};
    assign obj_rgn = ioctl_addr >= {3'd0, rom_pkg::OBJ_START} && !is_prom;

    always_comb begin
        dwn_data = ioctl_dout;
        dwn_addr = ioctl_addr;
        // Tile ROMs are stored with the nibbles the other way round
        if (scr_rgn) begin
            dwn_data = {ioctl_dout[3:0], ioctl_dout[7:4]};
        end
        // Object ROM lines are interleaved differently on the board
        if (obj_rgn) begin
            dwn_addr[15]  = ioctl_addr[0];
            dwn_addr[14]  = ioctl_addr[15];
            dwn_addr[0]   = ~ioctl_addr[14];
            dwn_addr[2:1] = ioctl_addr[5:4] + 2'd1;
            dwn_addr[6:3] = {ioctl_addr[6], ioctl_addr[3:1]};
        end
    end

endmodule

// File: rtl/prog_writer.sv
// SDRAM programming writer
module prog_writer (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic        ioctl_wr,
    input  logic [24:0] dwn_addr,
    input  logic [ 7:0] dwn_data,
    input  logic        is_prom,
    input  logic        sdram_ack,
    output logic [21:0] prog_addr,
    output logic [ 7:0] prog_data,
    output logic [ 1:0] prog_mask,
    output logic        prog_we,
    output logic        prom_we
);

    logic accept;

    assign accept = ioctl_wr && downloading;

    // Write strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= accept && is_prom;
            if (accept && !is_prom) begin
                prog_we <= 1'b1;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;
            end
        end
    end

    // Byte, word address and lane mask
    always_ff @(posedge clk) begin
        if (accept) begin
            prog_data <= dwn_data;
            if (is_prom) begin
                // PROMs are byte wide, keep the byte offset
                prog_addr <= dwn_addr[21:0] - rom_pkg::PROM_START[21:0];
                prog_mask <= 2'b11;
            end else begin
                prog_addr <= dwn_addr[22:1];
                prog_mask <= dwn_addr[0] ? 2'b01 : 2'b10;
            end
        end
    end

    // The loader waits for the SDRAM before sending the next byte
    a_no_wr_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        ioctl_wr |-> !prog_we
    );

endmodule

// File: rom_arb/rom_slot.sv
// ROM read slot with one-entry cache
module rom_slot (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic [ 1:0] id,
    rom_slot_if.slot    bus
);

    logic        req;
    logic        busy;
    logic        valid;
    logic        ok;
    logic [15:0] tag;
    logic [31:0] data;
    logic        wide;
    logic        hit;
    logic        start;
    logic        fill_done;
    logic [21:0] fetch_addr;

    // Only the scroll slot fetches 32 bits
    assign wide = id == rom_pkg::SLOT_SCR;

    assign hit       = valid && tag == bus.addr;
    assign start     = bus.cs && !hit && !req && !busy && !downloading;
    assign fill_done = wide ? bus.rdy : bus.dst;

    // Word address of the pending fetch
    always_comb begin
        case (id)
            rom_pkg::SLOT_SND: fetch_addr = rom_pkg::SND_START[21:1] + {7'd0, tag[15:1]};
            rom_pkg::SLOT_SCR: fetch_addr = rom_pkg::SCR_START[21:1] + {5'd0, tag, 1'b0};
            default:           fetch_addr = {7'd0, tag[15:1]};
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req   <= 1'b0;
            busy  <= 1'b0;
            valid <= 1'b0;
            ok    <= 1'b0;
        end else begin
            ok <= !downloading && bus.cs && tag == bus.addr && (valid || fill_done);
            if (bus.grant || downloading) begin
                req <= 1'b0;
            end else if (start) begin
                req <= 1'b1;
            end
            if (bus.grant) begin
                busy <= 1'b1;
            end else if (fill_done) begin
                busy <= 1'b0;
            end
            // ROM contents change during a download
            if (downloading || start) begin
                valid <= 1'b0;
            end else if (fill_done) begin
                valid <= 1'b1;
            end
        end
    end

    // Tag and returned data
    always_ff @(posedge clk) begin
        if (start) begin
            tag <= bus.addr;
        end
        if (bus.dst) begin
            if (wide) begin
                data[15:0] <= bus.word.whole;
            end else begin
                data <= {24'd0, tag[0] ? bus.word.bytes.hi : bus.word.bytes.lo};
            end
        end
        if (bus.rdy) begin
            data[31:16] <= bus.word.whole;
        end
    end

    assign bus.req        = req;
    assign bus.ok         = ok;
    assign bus.data       = data;
    assign bus.wide       = wide;
    assign bus.fetch_addr = fetch_addr;

    // A grant only answers the request this slot held up to it
    a_grant_for_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus.grant |-> req || busy
    );

endmodule

// File: rom_arb/rom_arbiter.sv
// SDRAM read arbiter
module rom_arbiter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    rom_slot_if.arb     main_bus,
    rom_slot_if.arb     snd_bus,
    rom_slot_if.arb     scr_bus,
    output logic        sdram_req,
    output logic [21:0] sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_dst,
    input  logic        data_rdy,
    input  logic [15:0] data_read
);

    logic [1:0] state;
    logic [1:0] sel;
    logic [1:0] pick;
    logic       any_req;
    logic       active;
    logic       sel_main;
    logic       sel_snd;
    logic       sel_scr;

    assign any_req = main_bus.req || snd_bus.req || scr_bus.req;

    // Fixed priority
    always_comb begin
        if (scr_bus.req) begin
            pick = rom_pkg::SLOT_SCR;
        end else if (snd_bus.req) begin
            pick = rom_pkg::SLOT_SND;
        end else begin
            pick = rom_pkg::SLOT_MAIN;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rom_pkg::ARB_IDLE;
            sel   <= rom_pkg::SLOT_MAIN;
        end else begin
            case (state)
                rom_pkg::ARB_IDLE: begin
                    if (any_req && !downloading) begin
                        sel   <= pick;
                        state <= rom_pkg::ARB_REQ;
                    end
                end
                rom_pkg::ARB_REQ: begin
                    if (sdram_ack) begin
                        state <= rom_pkg::ARB_RECV;
                    end
                end
                rom_pkg::ARB_RECV: begin
                    // Second burst word closes the fetch
                    if (data_rdy) begin
                        state <= rom_pkg::ARB_IDLE;
                    end
                end
                default: state <= rom_pkg::ARB_IDLE;
            endcase
        end
    end

    assign active    = state != rom_pkg::ARB_IDLE;
    assign sel_main  = active && sel == rom_pkg::SLOT_MAIN;
    assign sel_snd   = active && sel == rom_pkg::SLOT_SND;
    assign sel_scr   = active && sel == rom_pkg::SLOT_SCR;
    assign sdram_req = state == rom_pkg::ARB_REQ;

    always_comb begin
        case (sel)
            rom_pkg::SLOT_SCR: sdram_addr = scr_bus.fetch_addr;
            rom_pkg::SLOT_SND: sdram_addr = snd_bus.fetch_addr;
            default:           sdram_addr = main_bus.fetch_addr;
        endcase
    end

    // Grant only while the request is open
    assign main_bus.grant = sdram_req && sel_main;
    assign snd_bus.grant  = sdram_req && sel_snd;
    assign scr_bus.grant  = sdram_req && sel_scr;

    // Returned words go to the selected slot only
    assign main_bus.word = sel_main ? data_read : 16'd0;
    assign snd_bus.word  = sel_snd  ? data_read : 16'd0;
    assign scr_bus.word  = sel_scr  ? data_read : 16'd0;

    assign main_bus.dst = data_dst && sel_main;
    assign snd_bus.dst  = data_dst && sel_snd;
    assign scr_bus.dst  = data_dst && sel_scr;

    // Byte slots have no use for the second word
    assign main_bus.rdy = data_rdy && sel_main && main_bus.wide;
    assign snd_bus.rdy  = data_rdy && sel_snd  && snd_bus.wide;
    assign scr_bus.rdy  = data_rdy && sel_scr  && scr_bus.wide;

    // Burst words only arrive for an accepted read
    a_data_in_recv: assert property (
        @(posedge clk) disable iff (!rst_n)
        (data_dst || data_rdy) |-> state == rom_pkg::ARB_RECV
    );

endmodule

// File: rtl/rom_subsys.sv
// ROM subsystem top level
module rom_subsys (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          downloading,
    // Loader
    input  logic [24:0]                   ioctl_addr,
    input  logic [ 7:0]                   ioctl_dout,
    input  logic                          ioctl_wr,
    output logic [rom_pkg::SDRAM_AW-1:0]  prog_addr,
    output logic [ 7:0]                   prog_data,
    output logic [ 1:0]                   prog_mask,
    output logic                          prog_we,
    output logic                          prom_we,
    // Main CPU
    input  logic [rom_pkg::MAIN_AW-1:0]   main_addr,
    input  logic                          main_cs,
    output logic                          main_ok,
    output logic [ 7:0]                   main_data,
    // Sound CPU
    input  logic [rom_pkg::SND_AW-1:0]    snd_addr,
    input  logic                          snd_cs,
    output logic                          snd_ok,
    output logic [ 7:0]                   snd_data,
    // Scroll tiles
    input  logic [rom_pkg::SCR_AW-1:0]    scr_addr,
    input  logic                          scr_cs,
    output logic                          scr_ok,
    output logic [31:0]                   scr_data,
    // SDRAM read port
    output logic                          sdram_req,
    output logic [rom_pkg::SDRAM_AW-1:0]  sdram_addr,
    input  logic                          sdram_ack,
    input  logic                          data_dst,
    input  logic                          data_rdy,
    input  logic [15:0]                   data_read
);

    logic [24:0] dwn_addr;
    logic [ 7:0] dwn_data;
    logic        is_prom;

    rom_slot_if main_if ();
    rom_slot_if snd_if ();
    rom_slot_if scr_if ();

    dwnld_remap u_remap (
        .ioctl_addr ( ioctl_addr ),
        .ioctl_dout ( ioctl_dout ),
        .dwn_addr   ( dwn_addr   ),
        .dwn_data   ( dwn_data   ),
        .is_prom    ( is_prom    )
    );

    prog_writer u_writer (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .dwn_addr    ( dwn_addr    ),
        .dwn_data    ( dwn_data    ),
        .is_prom     ( is_prom     ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     )
    );

    // Client side of each slot, high address bits held at zero
    assign main_if.addr = main_addr;
    assign main_if.cs   = main_cs;
    assign snd_if.addr  = {2'd0, snd_addr};
    assign snd_if.cs    = snd_cs;
    assign scr_if.addr  = {3'd0, scr_addr};
    assign scr_if.cs    = scr_cs;

    assign main_ok   = main_if.ok;
    assign main_data = main_if.data[7:0];
    assign snd_ok    = snd_if.ok;
    assign snd_data  = snd_if.data[7:0];
    assign scr_ok    = scr_if.ok;
    assign scr_data  = scr_if.data;

    rom_slot u_main_slot (
        .clk         ( clk                ),
        .rst_n       ( rst_n              ),
        .downloading ( downloading        ),
        .id          ( rom_pkg::SLOT_MAIN ),
        .bus         ( main_if.slot       )
    );

    rom_slot u_snd_slot (
        .clk         ( clk                ),
        .rst_n       ( rst_n              ),
        .downloading ( downloading        ),
        .id          ( rom_pkg::SLOT_SND  ),
        .bus         ( snd_if.slot        )
    );

    rom_slot u_scr_slot (
        .clk         ( clk                ),
        .rst_n       ( rst_n              ),
        .downloading ( downloading        ),
        .id          ( rom_pkg::SLOT_SCR  ),
        .bus         ( scr_if.slot        )
    );

    rom_arbiter u_arbiter (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .downloading ( downloading  ),
        .main_bus    ( main_if.arb  ),
        .snd_bus     ( snd_if.arb   ),
        .scr_bus     ( scr_if.arb   ),
        .sdram_req   ( sdram_req    ),
        .sdram_addr  ( sdram_addr   ),
        .sdram_ack   ( sdram_ack    ),
        .data_dst    ( data_dst     ),
        .data_rdy    ( data_rdy     ),
        .data_read   ( data_read    )
    );

endmodule

// File: bench/sdram_model.sv
// Behavioral SDRAM
module sdram_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sdram_req,
    input  logic [21:0] sdram_addr,
    input  logic        prog_we,
    output logic        sdram_ack,
    output logic        data_dst,
    output logic        data_rdy,
    output logic [15:0] data_read
);
    timeunit 1ns;
    timeprecision 100ps;

    integer      seed;
    integer      delay;
    logic        is_read;
    logic [21:0] addr;

    initial begin
        seed      = 97;
        sdram_ack = 1'b0;
        data_dst  = 1'b0;
        data_rdy  = 1'b0;
        data_read = 16'd0;
        forever begin
            @(posedge clk);
            #2;
            if (rst_n && (sdram_req || prog_we)) begin
                is_read = sdram_req;
                addr    = sdram_addr;
                // One to four cycles until the access is taken
                delay = 1 + (($random(seed) & 32'h7FFF_FFFF) % 4);
                repeat (delay - 1) begin
                    @(posedge clk);
                    #2;
                end
                sdram_ack = 1'b1;
                @(posedge clk);
                #2;
                sdram_ack = 1'b0;
                if (is_read) begin
                    // Burst of two words, pattern follows the word address
                    data_dst  = 1'b1;
                    data_read = addr[15:0] ^ 16'h5A3C;
                    @(posedge clk);
                    #2;
                    data_dst  = 1'b0;
                    data_rdy  = 1'b1;
                    data_read = (addr[15:0] + 16'd1) ^ 16'h5A3C;
                    @(posedge clk);
                    #2;
                    data_rdy  = 1'b0;
                    data_read = 16'd0;
                end
            end
        end
    end

endmodule

// File: bench/tb_rom_subsys.sv
// ROM subsystem testbench
module tb_rom_subsys;
    timeunit 1ns;
    timeprecision 100ps;

    // About 600 cycles of tests and five times that as the limit
    localparam int CYCLE_LIMIT = 3000;

    logic        clk;
    logic        rst_n;
    logic        downloading;
    logic [24:0] ioctl_addr;
    logic [ 7:0] ioctl_dout;
    logic        ioctl_wr;
    logic [21:0] prog_addr;
    logic [ 7:0] prog_data;
    logic [ 1:0] prog_mask;
    logic        prog_we;
    logic        prom_we;
    logic [15:0] main_addr;
    logic        main_cs;
    logic        main_ok;
    logic [ 7:0] main_data;
    logic [13:0] snd_addr;
    logic        snd_cs;
    logic        snd_ok;
    logic [ 7:0] snd_data;
    logic [12:0] scr_addr;
    logic        scr_cs;
    logic        scr_ok;
    logic [31:0] scr_data;
    logic        sdram_req;
    logic [21:0] sdram_addr;
    logic        sdram_ack;
    logic        data_dst;
    logic        data_rdy;
    logic [15:0] data_read;

    logic [21:0] req_log[$];
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;
    int          errs;
    int          n;

    rom_subsys dut (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     ),
        .main_addr   ( main_addr   ),
        .main_cs     ( main_cs     ),
        .main_ok     ( main_ok     ),
        .main_data   ( main_data   ),
        .snd_addr    ( snd_addr    ),
        .snd_cs      ( snd_cs      ),
        .snd_ok      ( snd_ok      ),
        .snd_data    ( snd_data    ),
        .scr_addr    ( scr_addr    ),
        .scr_cs      ( scr_cs      ),
        .scr_ok      ( scr_ok      ),
        .scr_data    ( scr_data    ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_ack   ( sdram_ack   ),
        .data_dst    ( data_dst    ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   )
    );

    sdram_model u_sdram (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .prog_we    ( prog_we    ),
        .sdram_ack  ( sdram_ack  ),
        .data_dst   ( data_dst   ),
        .data_rdy   ( data_rdy   ),
        .data_read  ( data_read  )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Read requests taken by the SDRAM and sampled mid cycle
    always @(negedge clk) begin
        if (rst_n && sdram_req && sdram_ack) begin
            req_log.push_back(sdram_addr);
        end
    end

    // Protocol rules
    a_prom_alone: assert property (@(posedge clk) disable iff (!rst_n)
        prom_we |-> !prog_we)
        else begin
            $display("%0d ns: prom_we and prog_we were high together", $time);
            fail_count++;
        end

    a_prom_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        prom_we |=> !prom_we)
        else begin
            $display("%0d ns: prom_we stayed high for more than one cycle", $time);
            fail_count++;
        end

    a_write_hold: assert property (@(posedge clk) disable iff (!rst_n)
        prog_we && !sdram_ack |=> prog_we)
        else begin
            $display("%0d ns: prog_we dropped before sdram_ack", $time);
            fail_count++;
        end

    a_read_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req)
        else begin
            $display("%0d ns: sdram_req dropped before sdram_ack", $time);
            fail_count++;
        end

    a_download_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        downloading |=> !sdram_req && !main_ok && !snd_ok && !scr_ok)
        else begin
            $display("%0d ns: a slot read was active during the download", $time);
            fail_count++;
        end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) begin
            pass_count++;
        end else begin
            $display("CHECK FAILED at %0d ns: %s expected %h, got %h", $time, name, exp, act);
            fail_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %-16s finished with %0d errors", name, fail_count - errs_before);
    endtask

    // Loader address after the object region scramble
    function automatic logic [24:0] remap_addr(input logic [24:0] a);
        logic [24:0] r;
        int          grp;
        r = a;
        if (a >= {3'd0, rom_pkg::OBJ_START} && a < rom_pkg::PROM_START) begin
            grp   = (a >> 4) & 3;
            grp   = (grp + 1) % 4;
            r[15] = a[0];
            r[14] = a[15];
            r[0]  = ~a[14];
            r[2]  = grp[1];
            r[1]  = grp[0];
            r[6]  = a[6];
            r[5]  = a[3];
            r[4]  = a[2];
            r[3]  = a[1];
        end
        return r;
    endfunction

    function automatic logic [7:0] remap_data(input logic [24:0] a, input logic [7:0] d);
        if (a >= {3'd0, rom_pkg::SCR_START} && a < {3'd0, rom_pkg::OBJ_START}) begin
            return {d[3:0], d[7:4]};
        end
        return d;
    endfunction

    task automatic load_byte(input logic [24:0] a, input logic [7:0] d);
        logic [24:0] r;
        r          = remap_addr(a);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        next_cycle();
        ioctl_wr = 1'b0;
        if (a >= rom_pkg::PROM_START) begin
            check_val("prom_we", 1'b1, prom_we);
            check_val("prog_we", 1'b0, prog_we);
            next_cycle();
            check_val("prom_we", 1'b0, prom_we);
        end else begin
            check_val("prog_we", 1'b1, prog_we);
            check_val("prog_addr", r[22:1], prog_addr);
            check_val("prog_data", remap_data(a, d), prog_data);
            check_val("prog_mask", r[0] ? 2'b01 : 2'b10, prog_mask);
            while (prog_we) begin
                next_cycle();
            end
        end
    endtask

    function automatic logic [21:0] word_addr(input logic [1:0] sel, input logic [15:0] a);
        case (sel)
            rom_pkg::SLOT_SND: return rom_pkg::SND_START / 2 + a / 2;
            rom_pkg::SLOT_SCR: return rom_pkg::SCR_START / 2 + 2 * a;
            default:           return a / 2;
        endcase
    endfunction

    function automatic logic [31:0] expected_data(input logic [1:0] sel, input logic [15:0] a);
        logic [21:0] wa;
        logic [15:0] w0;
        logic [15:0] w1;
        wa = word_addr(sel, a);
        w0 = wa[15:0] ^ 16'h5A3C;
        w1 = wa[15:0] + 16'd1;
        w1 = w1 ^ 16'h5A3C;
        if (sel == rom_pkg::SLOT_SCR) begin
            return {w1, w0};
        end
        // Odd byte address takes the high byte
        return {24'd0, a[0] ? w0[15:8] : w0[7:0]};
    endfunction

    function automatic logic slot_ok(input logic [1:0] sel);
        case (sel)
            rom_pkg::SLOT_SND: return snd_ok;
            rom_pkg::SLOT_SCR: return scr_ok;
            default:           return main_ok;
        endcase
    endfunction

    function automatic logic [31:0] slot_data(input logic [1:0] sel);
        case (sel)
            rom_pkg::SLOT_SND: return {24'd0, snd_data};
            rom_pkg::SLOT_SCR: return scr_data;
            default:           return {24'd0, main_data};
        endcase
    endfunction

    task automatic set_slot(input logic [1:0] sel, input logic [15:0] a, input logic cs);
        case (sel)
            rom_pkg::SLOT_SND: begin
                snd_addr = a[13:0];
                snd_cs   = cs;
            end
            rom_pkg::SLOT_SCR: begin
                scr_addr = a[12:0];
                scr_cs   = cs;
            end
            default: begin
                main_addr = a;
                main_cs   = cs;
            end
        endcase
    endtask

    task automatic wait_slot_ok(input logic [1:0] sel);
        do begin
            next_cycle();
        end while (!slot_ok(sel));
    endtask

    task automatic release_slots();
        main_cs = 1'b0;
        snd_cs  = 1'b0;
        scr_cs  = 1'b0;
        next_cycle();
    endtask

    // Miss followed by a wait for ok and a compare of data and request address
    task automatic fetch_check(input logic [1:0] sel, input logic [15:0] a);
        int count;
        count = req_log.size();
        set_slot(sel, a, 1'b1);
        wait_slot_ok(sel);
        check_val("slot data", expected_data(sel, a), slot_data(sel));
        check_val("sdram request count", count + 1, req_log.size());
        check_val("sdram_addr", word_addr(sel, a), req_log[count]);
    endtask

    initial begin
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = 25'd0;
        ioctl_dout  = 8'd0;
        ioctl_wr    = 1'b0;
        main_addr   = 16'd0;
        main_cs     = 1'b0;
        snd_addr    = 14'd0;
        snd_cs      = 1'b0;
        scr_addr    = 13'd0;
        scr_cs      = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();

        errs = fail_count;
        check_val("sdram_req", 1'b0, sdram_req);
        check_val("prog_we", 1'b0, prog_we);
        check_val("prom_we", 1'b0, prom_we);
        check_val("main_ok", 1'b0, main_ok);
        check_val("snd_ok", 1'b0, snd_ok);
        check_val("scr_ok", 1'b0, scr_ok);
        report_test("reset state", errs);

        // Main, scroll and object regions
        errs        = fail_count;
        downloading = 1'b1;
        // Slot reads stay idle while the ROMs load
        set_slot(rom_pkg::SLOT_MAIN, 16'h0040, 1'b1);
        set_slot(rom_pkg::SLOT_SND, 16'h0011, 1'b1);
        set_slot(rom_pkg::SLOT_SCR, 16'h0100, 1'b1);
        next_cycle();
        load_byte(25'h00_0100, 8'h3C);
        load_byte(25'h00_1235, 8'hA7);
        load_byte(25'h01_4003, 8'h5E);
        load_byte(25'h01_7FF0, 8'h0F);
        load_byte(25'h01_C0B6, 8'h81);
        load_byte(25'h01_FF3D, 8'h42);
        report_test("download remap", errs);

        errs = fail_count;
        load_byte(rom_pkg::PROM_START, 8'h07);
        load_byte(rom_pkg::PROM_START + 25'd1, 8'h1B);
        load_byte(rom_pkg::PROM_START + 25'h100, 8'hF0);
        check_val("prog_we", 1'b0, prog_we);
        release_slots();
        downloading = 1'b0;
        next_cycle();
        report_test("prom strobes", errs);

        errs = fail_count;
        fetch_check(rom_pkg::SLOT_MAIN, 16'h1235);
        n = req_log.size();
        main_cs = 1'b0;
        next_cycle();
        main_cs = 1'b1;
        next_cycle();
        // Cached address answers one cycle after cs
        check_val("main_ok", 1'b1, main_ok);
        check_val("sdram request count", n, req_log.size());
        fetch_check(rom_pkg::SLOT_SND, 16'h0A54);
        set_slot(rom_pkg::SLOT_SND, 16'h0A55, 1'b1);
        next_cycle();
        check_val("snd_ok", 1'b0, snd_ok);
        fetch_check(rom_pkg::SLOT_SND, 16'h0A55);
        release_slots();
        report_test("byte reads", errs);

        errs = fail_count;
        fetch_check(rom_pkg::SLOT_SCR, 16'h0123);
        release_slots();
        report_test("scroll read", errs);

        errs = fail_count;
        n = req_log.size();
        set_slot(rom_pkg::SLOT_MAIN, 16'h4000, 1'b1);
        set_slot(rom_pkg::SLOT_SND, 16'h0003, 1'b1);
        set_slot(rom_pkg::SLOT_SCR, 16'h1FFE, 1'b1);
        do begin
            next_cycle();
        end while (!(main_ok && snd_ok && scr_ok));
        check_val("main_data", expected_data(rom_pkg::SLOT_MAIN, 16'h4000), main_data);
        check_val("snd_data", expected_data(rom_pkg::SLOT_SND, 16'h0003), snd_data);
        check_val("scr_data", expected_data(rom_pkg::SLOT_SCR, 16'h1FFE), scr_data);
        check_val("sdram request count", n + 3, req_log.size());
        check_val("sdram_addr first", word_addr(rom_pkg::SLOT_SCR, 16'h1FFE), req_log[n]);
        check_val("sdram_addr second", word_addr(rom_pkg::SLOT_SND, 16'h0003), req_log[n + 1]);
        check_val("sdram_addr third", word_addr(rom_pkg::SLOT_MAIN, 16'h4000), req_log[n + 2]);
        release_slots();
        report_test("priority", errs);

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
common/rom_pkg.sv
common/rom_slot_if.sv
rtl/dwnld_remap.sv
rtl/prog_writer.sv
rom_arb/rom_slot.sv
rom_arb/rom_arbiter.sv
rtl/rom_subsys.sv
bench/sdram_model.sv
bench/tb_rom_subsys.sv

// File: Bender.yml
package:
  name: rom_subsys

sources:
  - common/rom_pkg.sv
  - common/rom_slot_if.sv
  - rtl/dwnld_remap.sv
  - rtl/prog_writer.sv
  - rom_arb/rom_slot.sv
  - rom_arb/rom_arbiter.sv
  - rtl/rom_subsys.sv
  - target: test
    files:
      - bench/sdram_model.sv
      - bench/tb_rom_subsys.sv
